// File: core_mem_settings.svh
`ifndef CORE_MEM_SETTINGS_SVH
`define CORE_MEM_SETTINGS_SVH

// byte address width of the core and of the ram port
`define CORE_ADDR_W 16

// ram size in bytes, covers the whole address space
`define RAM_BYTES 65536

// instruction queue slots
// also the number of fetch credits after reset or redirect
`define IQ_DEPTH 4

`endif

// File: mem_types_pkg.sv
`default_nettype none

`include "core_mem_settings.svh"

package mem_types_pkg;

    // byte address, big-endian words sit on 4-byte boundaries
    typedef logic [`CORE_ADDR_W-1:0] addr_t;

    // one ram location
    typedef logic [7:0] byte_t;

    // instruction or data word, byte at the word address in [31:24]
    typedef logic [31:0] word_t;

    // fetch credits, 0 up to and including IQ_DEPTH
    typedef logic [$clog2(`IQ_DEPTH + 1)-1:0] credit_t;

    // controller states
    // sequencing inside a state is done by a byte counter
    typedef enum logic [1:0] {
        IDLE,   // arbitrating, data first
        FETCH,  // four byte reads then push to queue
        LOAD,   // four byte reads then data done
        STORE   // four byte writes then data done
    } mc_state_e;

endpackage

`default_nettype wire

// File: core_if_pkg.sv
`default_nettype none

package core_if_pkg;

    import mem_types_pkg::*;

    // fetch unit to controller
    typedef struct packed {
        logic  valid;  // credit available
        addr_t addr;   // pc of the word to fetch
    } fetch_req_t;

    // controller to queue, queue to decode
    typedef struct packed {
        logic  valid;
        addr_t pc;     // address the word came from
        word_t inst;
    } inst_pkt_t;

    // core load/store port, held until data done
    typedef struct packed {
        logic  valid;
        logic  wr;     // 1 store, 0 load
        addr_t addr;   // word aligned
        word_t wdata;  // store only
    } data_req_t;

endpackage

`default_nettype wire

// File: fetch_pc.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_mem_settings.svh"

module fetch_pc (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        redirect_i,     // branch taken in the core
    input  wire mem_types_pkg::addr_t  redirect_pc_i,
    input  wire                        fetch_ack_i,    // controller took the request
    input  wire                        credit_ret_i,   // queue popped one word
    output core_if_pkg::fetch_req_t    fetch_req_o
);

    import mem_types_pkg::*;

    addr_t   pc_q;       // next word to fetch
    credit_t credits_q;  // free queue slots not yet claimed
    logic    spend;      // a fetch was accepted this cycle

    // offer a fetch whenever a slot is free
    always_comb begin
        fetch_req_o.valid = (credits_q != '0);
        fetch_req_o.addr  = pc_q;
    end

    assign spend = fetch_req_o.valid && fetch_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q      <= '0;
            credits_q <= credit_t'(`IQ_DEPTH);
        end else if (redirect_i) begin
            // queue and any fetch in flight are dropped
            // so all slots are free again
            pc_q      <= redirect_pc_i;
            credits_q <= credit_t'(`IQ_DEPTH);
        end else begin
            if (spend) begin
                pc_q <= pc_q + addr_t'(4);  // sequential only
            end
            credits_q <= credits_q + credit_t'(credit_ret_i) - credit_t'(spend);
        end
    end

    // credits + queued + in flight stays at IQ_DEPTH
    // a stray return from the queue would push this over
    a_credit_max: assert property (@(posedge clk) disable iff (reset_i)
        credits_q <= credit_t'(`IQ_DEPTH));

endmodule

`default_nettype wire

// File: mem_control.sv
`default_nettype none
`timescale 1ns/100ps

module mem_control (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          redirect_i,
    // fetch side
    input  wire core_if_pkg::fetch_req_t fetch_req_i,
    output logic                         fetch_ack_o,
    // data side, request held until done
    input  wire core_if_pkg::data_req_t  data_req_i,
    output logic                         data_done_o,
    output mem_types_pkg::word_t         rdata_o,
    // byte ram port
    output mem_types_pkg::addr_t         ram_addr_o,
    output logic                         ram_wr_o,
    output mem_types_pkg::byte_t         ram_wdata_o,
    input  wire mem_types_pkg::byte_t    ram_rdata_i,
    // to instruction queue
    output core_if_pkg::inst_pkt_t       iq_push_o
);

    import mem_types_pkg::*;
    import core_if_pkg::*;

    mc_state_e  state_q;
    logic [2:0] cnt_q;    // cycle of the access, accept cycle is 0
    addr_t      base_q;   // word address of the access
    word_t      word_q;   // read bytes shift in low, store bytes shift out high
    word_t      rdata_q;  // last load result

    logic  idle;
    logic  take_data;     // data wins when both ask
    logic  take_fetch;
    logic  last_step;     // final cycle of a busy state
    word_t word_in;       // word with the byte arriving now

    always_comb begin
        idle       = (state_q == IDLE);
        take_data  = idle && data_req_i.valid;
        // no fetch from the old pc while a redirect is on the wire
        take_fetch = idle && !data_req_i.valid && fetch_req_i.valid && !redirect_i;
        // store done in cycle 4, fetch and load run to cycle 5
        last_step  = (state_q == STORE) ? (cnt_q == 3'd4) : (cnt_q == 3'd5);
        word_in    = {word_q[23:0], ram_rdata_i};  // high byte first
    end

    assign fetch_ack_o = take_fetch;

    // byte 0 goes out in the accept cycle straight from the request
    always_comb begin
        if (idle) begin
            ram_addr_o = data_req_i.valid ? data_req_i.addr : fetch_req_i.addr;
        end else begin
            ram_addr_o = base_q + addr_t'(cnt_q);  // base+1 .. base+3, later reads unused
        end
    end

    // store writes in cycles 0..3
    assign ram_wr_o    = (take_data && data_req_i.wr) || (state_q == STORE && cnt_q <= 3'd3);
    assign ram_wdata_o = idle ? data_req_i.wdata[31:24] : word_q[31:24];

    // load done one cycle after the fourth byte is captured
    assign data_done_o = (state_q == LOAD && cnt_q == 3'd5) ||
                         (state_q == STORE && cnt_q == 3'd4);
    assign rdata_o     = rdata_q;

    // push as the fourth byte arrives, lands in the queue at the edge
    always_comb begin
        iq_push_o.valid = (state_q == FETCH) && (cnt_q == 3'd4) && !redirect_i;
        iq_push_o.pc    = base_q;
        iq_push_o.inst  = word_in;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (idle) begin
            cnt_q <= 3'd1;  // first busy cycle
            if (take_data) begin
                state_q <= data_req_i.wr ? STORE : LOAD;
            end else if (take_fetch) begin
                state_q <= FETCH;
            end
        end else if ((state_q == FETCH && redirect_i) || last_step) begin
            // abandoned fetch reads are harmless, nothing pushed
            state_q <= IDLE;
        end else begin
            cnt_q <= cnt_q + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take_data || take_fetch) begin
            base_q <= ram_addr_o;
            word_q <= {data_req_i.wdata[23:0], 8'h00};  // bytes 1..3 of a store
        end else if (state_q == STORE) begin
            word_q <= {word_q[23:0], 8'h00};
        end else if (!idle && cnt_q <= 3'd4) begin
            word_q <= word_in;  // capture cycles 1..4
        end
        if (state_q == LOAD && cnt_q == 3'd4) begin
            rdata_q <= word_in;  // kept until the next load
        end
    end

    // every write is followed by more store cycles, never by idle
    a_wr_in_store: assert property (@(posedge clk) disable iff (reset_i)
        ram_wr_o |=> (state_q == STORE));

    // load result comes five cycles after accept
    a_load_done: assert property (@(posedge clk) disable iff (reset_i)
        (take_data && !data_req_i.wr) |-> ##5 data_done_o);

endmodule

`default_nettype wire

// File: byte_ram.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_mem_settings.svh"

module byte_ram (
    input  wire                        clk,
    input  wire mem_types_pkg::addr_t  addr_i,
    input  wire                        wr_i,
    input  wire mem_types_pkg::byte_t  wdata_i,
    output mem_types_pkg::byte_t       rdata_o   // valid the cycle after addr_i
);

    import mem_types_pkg::*;

    byte_t mem_q [`RAM_BYTES];  // one byte per address

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i];  // read before write, old byte
    end

endmodule

`default_nettype wire

// File: inst_queue.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_mem_settings.svh"

module inst_queue (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          redirect_i,   // flush
    input  wire core_if_pkg::inst_pkt_t  push_i,
    input  wire                          pop_i,
    output core_if_pkg::inst_pkt_t       head_o,
    output logic                         credit_ret_o  // one pulse per pop
);

    import core_if_pkg::*;

    localparam int PTR_W = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    inst_pkt_t        mem_q [`IQ_DEPTH];  // packet storage
    logic [PTR_W-1:0] rd_q;
    logic [PTR_W-1:0] wr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    // circular pointer step
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`IQ_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    // flush wins over push and pop in the same cycle
    assign push_ok = push_i.valid && !redirect_i;
    assign pop_ok  = pop_i && head_o.valid && !redirect_i;  // empty pops ignored

    always_comb begin
        head_o       = mem_q[rd_q];
        head_o.valid = (count_q != '0);
    end

    always_ff @(posedge clk) begin
        if (reset_i || redirect_i) begin
            rd_q    <= '0;
            wr_q    <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) begin
                wr_q <= ptr_next(wr_q);
            end
            if (pop_ok) begin
                rd_q <= ptr_next(rd_q);
            end
            count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_q] <= push_i;
        end
    end

    // flushed entries are not returned, fetch resets its credits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_ret_o <= 1'b0;
        end else begin
            credit_ret_o <= pop_ok;
        end
    end

    // credits in the fetch unit must keep the queue from overflowing
    a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        push_i.valid |-> (count_q != CNT_W'(`IQ_DEPTH)));

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_top (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          redirect_i,
    input  wire mem_types_pkg::addr_t    redirect_pc_i,
    input  wire core_if_pkg::data_req_t  data_req_i,
    output logic                         data_done_o,
    output mem_types_pkg::word_t         rdata_o,
    output core_if_pkg::inst_pkt_t       inst_o,      // queue head
    input  wire                          inst_pop_i
);

    import mem_types_pkg::*;
    import core_if_pkg::*;

    fetch_req_t fetch_req;   // fetch unit to controller
    logic       fetch_ack;
    logic       credit_ret;  // queue back to fetch unit
    inst_pkt_t  iq_push;     // controller to queue
    addr_t      ram_addr;
    logic       ram_wr;
    byte_t      ram_wdata;
    byte_t      ram_rdata;

    fetch_pc fetch_pc_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_ack_i   (fetch_ack),
        .credit_ret_i  (credit_ret),
        .fetch_req_o   (fetch_req)
    );

    mem_control mem_control_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .redirect_i  (redirect_i),
        .fetch_req_i (fetch_req),
        .fetch_ack_o (fetch_ack),
        .data_req_i  (data_req_i),
        .data_done_o (data_done_o),
        .rdata_o     (rdata_o),
        .ram_addr_o  (ram_addr),
        .ram_wr_o    (ram_wr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .iq_push_o   (iq_push)
    );

    byte_ram byte_ram_i (
        .clk     (clk),
        .addr_i  (ram_addr),
        .wr_i    (ram_wr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    inst_queue inst_queue_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .redirect_i   (redirect_i),
        .push_i       (iq_push),
        .pop_i        (inst_pop_i),
        .head_o       (inst_o),
        .credit_ret_o (credit_ret)
    );

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_mem_settings.svh"

module tb_mem_subsys;

    import mem_types_pkg::*;
    import core_if_pkg::*;

    localparam int CLK_HALF  = 50;
    localparam int DRIVE_DLY = 10;   // inputs move this long after the rising edge
    localparam int PROG_END  = 256;  // program and data both live in 0..255
    // tests need roughly 9000 cycles, eight fetch rounds dominate
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      redirect_i;
    addr_t     redirect_pc_i;
    data_req_t data_req_i;
    logic      data_done_o;
    word_t     rdata_o;
    inst_pkt_t inst_o;
    logic      inst_pop_i;

    byte_t  shadow [`RAM_BYTES];  // mirror of every completed store
    integer seed = 2294;
    int     exp_pc;               // pc of the next packet to pop
    int     pop_mode;             // 0 off, 1 every cycle, 2 random gaps
    int     cycle_count = 0;

    mem_subsys_top dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .data_req_i    (data_req_i),
        .data_done_o   (data_done_o),
        .rdata_o       (rdata_o),
        .inst_o        (inst_o),
        .inst_pop_i    (inst_pop_i)
    );

    always #CLK_HALF clk = ~clk;

    // big-endian word from the shadow, byte at addr is the high byte
    function automatic word_t expected_word(input addr_t addr);
        return {shadow[addr], shadow[addr + addr_t'(1)],
                shadow[addr + addr_t'(2)], shadow[addr + addr_t'(3)]};
    endfunction

    // aligned address of a random word in lo_word..hi_word
    function automatic addr_t random_word_addr(input int lo_word, input int hi_word);
        int offset;
        offset = {$random(seed)} % (hi_word - lo_word + 1);
        return addr_t'((lo_word + offset) * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // step to the drive point of the next cycle and set the pop line
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        redirect_i = 1'b0;  // redirect is a one-cycle pulse
        case (pop_mode)
            1: inst_pop_i = (exp_pc < PROG_END);
            2: inst_pop_i = (exp_pc < PROG_END) && (($random(seed) & 3) != 0);
            default: inst_pop_i = 1'b0;
        endcase
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic do_redirect(input addr_t target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        inst_pop_i    = 1'b0;  // no pop in the flush cycle
        next_cycle();
    endtask

    // hold the request until done, then mirror or check
    task automatic data_access(input logic wr, input addr_t addr, input word_t wdata);
        word_t got;
        data_req_i.valid = 1'b1;
        data_req_i.wr    = wr;
        data_req_i.addr  = addr;
        data_req_i.wdata = wdata;
        @(negedge clk);
        while (data_done_o !== 1'b1) begin
            next_cycle();
            @(negedge clk);
        end
        got = rdata_o;  // valid while done is high
        next_cycle();
        data_req_i = '0;
        if (wr) begin
            shadow[addr]              = wdata[31:24];
            shadow[addr + addr_t'(1)] = wdata[23:16];
            shadow[addr + addr_t'(2)] = wdata[15:8];
            shadow[addr + addr_t'(3)] = wdata[7:0];
        end else begin
            check_value("rdata_o", got, expected_word(addr));
        end
    endtask

    task automatic wait_pc(input int limit);
        while (exp_pc < limit) begin
            next_cycle();
        end
    endtask

    // pops held off, head must stay valid once something is queued
    task automatic stall_pops(input int cycles);
        logic seen_valid;
        seen_valid = 1'b0;
        pop_mode   = 0;
        repeat (cycles) begin
            next_cycle();
            @(negedge clk);
            if (seen_valid) begin
                check_value("inst_o.valid", 32'(inst_o.valid), 32'd1);
            end
            if (inst_o.valid) begin
                seen_valid = 1'b1;
            end
        end
    endtask

    // compare every pop against the shadow and the pc sequence
    always @(negedge clk) begin
        if (!reset_i) begin
            if (redirect_i) begin
                exp_pc = int'(redirect_pc_i);  // stream restarts at the target
            end else if (inst_pop_i && inst_o.valid) begin
                check_value("inst_o.pc", 32'(inst_o.pc), 32'(exp_pc));
                check_value("inst_o.inst", inst_o.inst, expected_word(inst_o.pc));
                exp_pc = exp_pc + 4;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        addr_t addr;
        int    room;
        reset_i       = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        data_req_i    = '0;
        inst_pop_i    = 1'b0;
        pop_mode      = 0;
        exp_pc        = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;

        // first cycle out of reset, queue empty and no data done
        @(negedge clk);
        check_value("inst_o.valid", 32'(inst_o.valid), 32'd0);
        check_value("data_done_o", 32'(data_done_o), 32'd0);
        next_cycle();

        // fill the program area, then read it back
        for (int i = 0; i < PROG_END; i += 4) begin
            data_access(1'b1, addr_t'(i), word_t'($random(seed)));
        end
        for (int i = 0; i < PROG_END; i += 4) begin
            data_access(1'b0, addr_t'(i), '0);
        end
        repeat (32) begin
            data_access(1'b0, random_word_addr(0, 63), '0);
        end

        // words queued before the stores are stale, flush and restart at 0
        do_redirect('0);
        pop_mode = 1;
        wait_pc(96);

        // back-pressure then resume
        stall_pops(60);
        pop_mode = 1;
        wait_pc(160);

        // redirects in the middle of a running stream
        repeat (4) begin
            addr = random_word_addr(0, 47);
            do_redirect(addr);
            wait_pc(int'(addr) + 32);
        end

        // data traffic mixed with fetch
        // stores go well past the fetch window so queued words stay current
        pop_mode = 2;
        for (int round = 0; round < 8; round++) begin
            do_redirect(random_word_addr(0, 15));
            while (exp_pc < PROG_END) begin
                idle_cycles(1 + {$random(seed)} % 8);  // at least one cycle for fetch
                room = (PROG_END - 4 - (exp_pc + 64)) / 4;
                if (exp_pc + 64 <= PROG_END - 4 && ($random(seed) & 1)) begin
                    addr = addr_t'(exp_pc + 64 + 4 * ({$random(seed)} % (room + 1)));
                    data_access(1'b1, addr, word_t'($random(seed)));
                end else begin
                    data_access(1'b0, random_word_addr(0, 63), '0);
                end
            end
        end

        pop_mode = 0;
        idle_cycles(2);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
mem_types_pkg.sv
core_if_pkg.sv
fetch_pc.sv
mem_control.sv
byte_ram.sv
inst_queue.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
